// ==== Bender.yml ====
package:
  name: mips_front_end

sources:
  - include_dirs:
      - include
    files:
      - source/mips_pkg.sv
      - source/fetchCounter.sv
      - source/fetchControl.sv
      - source/instrDecoder.sv
      - source/regFile.sv
      - source/decodeStage.sv
      - source/mipsFrontEnd.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/frontEndChecker.sv
      - bench/mipsFrontEnd_asserts.sv
      - bench/mipsFrontEnd_tb.sv

// ==== bench/frontEndChecker.sv ====
module frontEndChecker (
    input  logic              clk,
    input  logic              arstN,
    input  mips_pkg::fetchReq fetchReq,
    input  logic              fetchRespReady,
    input  mips_pkg::issueRec issue,
    input  logic              issueReady,
    output int                mismatchCount,
    output int                failCount,
    output int                expTotal,
    output logic              allMatched
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] expPc [$];
    string       expSym [$];
    logic [31:0] expWa [$];
    logic [31:0] expWd [$];
    logic [31:0] expRs [$];
    logic [31:0] expRt [$];
    int          matched;

    task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            mismatchCount++;
        end
    endtask

    // Expected issue records from the lines tagged E
    initial begin
        int          fd;
        int          n;
        string       line;
        string       tag;
        string       sym;
        logic [31:0] v [6];
        mismatchCount = 0;
        failCount     = 0;
        matched       = 0;
        fd = $fopen("bench/frontend_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] == "E") begin
                    n = $sscanf(line, "%s %h %s %h %h %h %h", tag, v[0], sym, v[1], v[2],
                                v[3], v[4]);
                    expPc.push_back(v[0]);
                    expSym.push_back(sym);
                    expWa.push_back(v[1]);
                    expWd.push_back(v[2]);
                    expRs.push_back(v[3]);
                    expRt.push_back(v[4]);
                end
            end
            $fclose(fd);
        end
        expTotal = expPc.size();
        if (expTotal == 0) begin
            $display("no expected issue records were found");
            failCount++;
        end
    end

    assign allMatched = (expTotal > 0) && (matched == expTotal);

    // Sample mid-cycle when inputs and outputs have settled
    always @(negedge clk) begin
        if (arstN) begin
            if (fetchReq.valid && fetchReq.pc[1:0] != 2'b00) begin
                $display("fetch request at %0t has an address that is not word aligned",
                         $time);
                failCount++;
            end
            // A stalled output register holds back the fetch responses
            if (issue.valid && !issueReady && fetchRespReady) begin
                $display("fetch responses taken at %0t while the issue record is stalled",
                         $time);
                failCount++;
            end
            if (issue.valid && issueReady) begin
                if (matched >= expTotal) begin
                    $display("issue of pc %h at %0t with no expected record left",
                             issue.pc, $time);
                    failCount++;
                end else begin
                    checkField("pc", expPc[matched], issue.pc);
                    if (issue.sym.name() != expSym[matched]) begin
                        $display("mismatch at %0t: sym expected %s actual %s", $time,
                                 expSym[matched], issue.sym.name());
                        mismatchCount++;
                    end
                    checkField("regWriteAddr", expWa[matched], 32'(issue.regWriteAddr));
                    checkField("regWriteData", expWd[matched], issue.regWriteData);
                    checkField("dataRs", expRs[matched], issue.dataRs);
                    checkField("dataRt", expRt[matched], issue.dataRt);
                    matched++;
                end
            end
        end
    end

endmodule

// ==== bench/frontend_golden.txt ====
# M addr code | R reg data | B pc reg data (write-back when pc is answered)
# E pc sym regWriteAddr regWriteData dataRs dataRt
R 00 00000123
R 01 00000005
R 02 00000005
R 03 00000007
R 04 fffffff0
R 0c 00000060
M 00 00232820
M 04 344600ff
M 08 3c071234
M 0c 00014022
M 10 10230008
M 14 10220002
M 18 00232820
M 1c 00232820
M 20 1c800005
M 24 04800002
M 28 344600ff
M 2c 344600ff
M 30 0c000010
M 34 00232820
M 40 01205020
M 44 01805809
M 48 00232820
M 60 14220004
M 64 08000019
B 40 09 cafe0001
E 00 ADD 05 00000000 00000005 00000007
E 04 ORI 06 00000000 00000005 00000000
E 08 LUI 07 12340000 00000000 00000000
E 0c SUB 08 00000000 00000000 00000005
E 10 BEQ 03 00000000 00000005 00000007
E 14 BEQ 02 00000000 00000005 00000005
E 20 BGTZ 00 00000000 fffffff0 00000000
E 24 BLTZ 00 00000000 fffffff0 00000000
E 30 JAL 1f 00000038 00000000 00000000
E 40 ADD 0a 00000000 cafe0001 00000000
E 44 JALR 0b 0000004c 00000060 00000000
E 60 BNE 02 00000000 00000005 00000005
E 64 J 00 00000000 00000000 00000000

// ==== bench/mipsFrontEnd_asserts.sv ====
`include "mips_consts.svh"

module mipsFrontEnd_asserts (
    input logic              clk,
    input logic              arstN,
    input mips_pkg::fetchReq fetchReq,
    input logic              fetchReqReady,
    input logic              redirectValid,
    input mips_pkg::issueRec issue,
    input logic              issueReady,
    input logic [1:0]        qCount
);

    timeunit 1ns;
    timeprecision 100ps;

    int assertFails = 0;

    // A redirect may retarget a waiting request
    reqHold: assert property (@(posedge clk) disable iff (!arstN)
        fetchReq.valid && !fetchReqReady && !redirectValid |=>
            fetchReq.valid && $stable(fetchReq.pc))
        else begin
            assertFails++;
            $error("fetch request changed while waiting for ready");
        end

    issueHold: assert property (@(posedge clk) disable iff (!arstN)
        issue.valid && !issueReady |=> issue.valid && $stable(issue))
        else begin
            assertFails++;
            $error("issue record changed while waiting for ready");
        end

    inFlightLimit: assert property (@(posedge clk) disable iff (!arstN)
        qCount <= `MAX_INFLIGHT)
        else begin
            assertFails++;
            $error("more fetch requests in flight than allowed");
        end

endmodule

bind mipsFrontEnd mipsFrontEnd_asserts mipsFrontEnd_asserts_inst (
    .clk           (clk),
    .arstN         (arstN),
    .fetchReq      (fetchReq),
    .fetchReqReady (fetchReqReady),
    .redirectValid (redirectValid),
    .issue         (issue),
    .issueReady    (issueReady),
    .qCount        (qCount)
);

// ==== bench/mipsFrontEnd_tb.sv ====
module mipsFrontEnd_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic               clk;
    logic               arstN;
    logic               fetchReqReady;
    mips_pkg::fetchResp fetchResp;
    mips_pkg::wbWrite   wb;
    logic               issueReady;
    mips_pkg::fetchReq  fetchReq;
    logic               fetchRespReady;
    mips_pkg::issueRec  issue;

    // Instruction memory of 64 words indexed by pc[7:2]
    logic [31:0] mem [64];
    logic [4:0]  preReg [$];
    logic [31:0] preData [$];
    logic [31:0] bypPc [$];
    logic [4:0]  bypReg [$];
    logic [31:0] bypData [$];
    bit          bypDone [$];
    logic [31:0] pendAddr [$];
    int          pendWait [$];
    logic [15:0] lfsrState;
    bit          bypassNow;

    int          mismatchCount;
    int          failCount;
    int          expTotal;
    logic        allMatched;
    int          assertCount;
    int          cycles;
    int          limit;
    bit          timedOut;
    bit          loadOk;
    logic        reqXfer;
    logic        respXfer;
    logic [31:0] reqAddr;

    mipsFrontEnd mipsFrontEnd_inst (
        .clk            (clk),
        .arstN          (arstN),
        .fetchReqReady  (fetchReqReady),
        .fetchResp      (fetchResp),
        .wb             (wb),
        .issueReady     (issueReady),
        .fetchReq       (fetchReq),
        .fetchRespReady (fetchRespReady),
        .issue          (issue)
    );

    frontEndChecker frontEndChecker_inst (
        .clk            (clk),
        .arstN          (arstN),
        .fetchReq       (fetchReq),
        .fetchRespReady (fetchRespReady),
        .issue          (issue),
        .issueReady     (issueReady),
        .mismatchCount  (mismatchCount),
        .failCount      (failCount),
        .expTotal       (expTotal),
        .allMatched     (allMatched)
    );

    always #5 clk = ~clk;

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [7:0] randBits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
            r = {r[6:0], lfsrState[0]};
        end
        return r;
    endfunction

    // Memory words, register preloads and bypass writes
    task automatic loadGolden();
        int          fd;
        int          n;
        string       line;
        string       tag;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        fd = $fopen("bench/frontend_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden data file");
            loadOk = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n <= 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s", tag);
            if (tag == "M") begin
                n = $sscanf(line, "%s %h %h", tag, a, d);
                mem[a[7:2]] = d;
            end else if (tag == "R") begin
                n = $sscanf(line, "%s %h %h", tag, r, d);
                preReg.push_back(r[4:0]);
                preData.push_back(d);
            end else if (tag == "B") begin
                n = $sscanf(line, "%s %h %h %h", tag, a, r, d);
                bypPc.push_back(a);
                bypReg.push_back(r[4:0]);
                bypData.push_back(d);
                bypDone.push_back(1'b0);
            end
        end
        $fclose(fd);
    endtask

    // Present the oldest response once its latency has run out
    task automatic driveResp();
        wb        = '0;
        bypassNow = 1'b0;
        if (pendAddr.size() > 0 && pendWait[0] == 0) begin
            fetchResp = {1'b1, mem[pendAddr[0][7:2]]};
            for (int i = 0; i < bypPc.size(); i++) begin
                if (!bypDone[i] && bypPc[i] == pendAddr[0]) begin
                    wb = '{en: 1'b1, addr: bypReg[i], data: bypData[i]};
                    bypDone[i] = 1'b1;
                    bypassNow  = 1'b1;
                end
            end
        end else begin
            fetchResp = '0;
        end
    endtask

    initial begin
        clk           = 1'b0;
        arstN         = 1'b0;
        fetchReqReady = 1'b0;
        fetchResp     = '0;
        wb            = '0;
        issueReady    = 1'b0;
        lfsrState     = 16'd34;
        bypassNow     = 1'b0;
        loadOk        = 1'b1;
        timedOut      = 1'b0;
        // Unwritten words hold opcode 0x3f and decode as NOP
        for (int i = 0; i < 64; i++) begin
            mem[i] = {6'h3f, 26'(i)};
        end
        loadGolden();
        repeat (8) @(posedge clk);
        #1 arstN = 1'b1;

        // Preloads while no fetch is granted
        for (int i = 0; i < preReg.size(); i++) begin
            @(posedge clk);
            #1 wb = '{en: 1'b1, addr: preReg[i], data: preData[i]};
        end
        @(posedge clk);
        #1 wb = '0;
        fetchReqReady = 1'b1;
        issueReady    = 1'b1;

        limit  = 40 * expTotal + 100;
        cycles = 0;
        while (loadOk && !allMatched && cycles < limit) begin
            @(negedge clk);
            reqXfer  = fetchReq.valid && fetchReqReady;
            reqAddr  = fetchReq.pc;
            respXfer = fetchResp.valid && fetchRespReady;
            @(posedge clk);
            #1;
            cycles++;
            if (respXfer) begin
                void'(pendAddr.pop_front());
                void'(pendWait.pop_front());
            end
            for (int i = 0; i < pendWait.size(); i++) begin
                if (pendWait[i] > 0) begin
                    pendWait[i]--;
                end
            end
            if (reqXfer) begin
                pendAddr.push_back(reqAddr);
                pendWait.push_back(int'(randBits(2)));
            end
            driveResp();
            fetchReqReady = (randBits(2) != 8'd0);
            // A response with a write-back is taken at once so the write meets the read
            issueReady    = (randBits(2) != 8'd0) || bypassNow;
        end
        if (loadOk && !allMatched) begin
            $display("timeout after %0d cycles with expected records still open", cycles);
            timedOut = 1'b1;
        end

        assertCount = mipsFrontEnd_inst.mipsFrontEnd_asserts_inst.assertFails;
        $display("mismatches %0d, other failures %0d", mismatchCount,
                 failCount + assertCount + int'(timedOut) + int'(!loadOk));
        if (loadOk && !timedOut && mismatchCount == 0 && failCount == 0
                && assertCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
source/mips_pkg.sv
source/fetchCounter.sv
source/fetchControl.sv
source/instrDecoder.sv
source/regFile.sv
source/decodeStage.sv
source/mipsFrontEnd.sv
bench/frontEndChecker.sv
bench/mipsFrontEnd_asserts.sv
bench/mipsFrontEnd_tb.sv

// ==== include/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Data path and address width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// Fetch requests allowed in flight at once
`define MAX_INFLIGHT 2

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== source/decodeStage.sv ====
`include "mips_consts.svh"

module decodeStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [`XLEN-1:0]      pc,
    input  mips_pkg::decodeFields fields,
    input  logic [`XLEN-1:0]      rsData,
    input  logic [`XLEN-1:0]      rtData,
    input  logic                  respAccept,
    input  logic                  issueReady,
    output logic                  outFree,
    output logic                  redirectValid,
    output logic [`XLEN-1:0]      redirectPc,
    output mips_pkg::issueRec     issue
);

    logic [`XLEN-1:0]       pcPlus4;
    logic [`XLEN-1:0]       branchOffset;
    logic                   rsNeg;
    logic                   rsZero;
    logic                   taken;
    logic                   isRFormat;
    logic [`REG_ADDR_W-1:0] regWriteAddr;
    logic [`XLEN-1:0]       regWriteData;
    mips_pkg::issueRec      recNext;
    mips_pkg::issueRec      recQ;
    logic                   validQ;

    assign pcPlus4      = pc + `XLEN'd4;
    assign branchOffset = {{(`XLEN-18){fields.imm16[15]}}, fields.imm16, 2'b00};
    assign rsNeg        = rsData[`XLEN-1];
    assign rsZero       = (rsData == '0);

    // Branch condition and target
    always_comb begin
        taken      = 1'b0;
        redirectPc = pcPlus4 + branchOffset;
        case (fields.sym)
            mips_pkg::BEQ:  taken = (rsData == rtData);
            mips_pkg::BNE:  taken = (rsData != rtData);
            mips_pkg::BLEZ: taken = rsNeg || rsZero;
            mips_pkg::BGTZ: taken = !rsNeg && !rsZero;
            mips_pkg::BLTZ: taken = rsNeg;
            mips_pkg::BGEZ: taken = !rsNeg;
            mips_pkg::J, mips_pkg::JAL: begin
                taken      = 1'b1;
                redirectPc = {pcPlus4[`XLEN-1:`XLEN-4], fields.jmpAddr, 2'b00};
            end
            mips_pkg::JR, mips_pkg::JALR: begin
                taken      = 1'b1;
                redirectPc = rsData;
            end
            default: taken = 1'b0;
        endcase
    end

    assign redirectValid = respAccept && taken;

    always_comb begin
        case (fields.sym)
            mips_pkg::ADD, mips_pkg::SUB, mips_pkg::ADDU, mips_pkg::SUBU,
            mips_pkg::AND, mips_pkg::OR, mips_pkg::XOR, mips_pkg::NOR,
            mips_pkg::SLT, mips_pkg::SLTU, mips_pkg::SLL, mips_pkg::SLLV,
            mips_pkg::SRL, mips_pkg::SRLV, mips_pkg::SRA, mips_pkg::SRAV,
            mips_pkg::JALR, mips_pkg::JR: isRFormat = 1'b1;
            default: isRFormat = 1'b0;
        endcase
    end

    // Destination register and the values known already at decode
    assign regWriteAddr = (fields.sym == mips_pkg::JAL) ? `REG_ADDR_W'(`REG_COUNT - 1) :
                          isRFormat ? fields.rd : fields.rt;
    assign regWriteData = (fields.sym == mips_pkg::JAL || fields.sym == mips_pkg::JALR) ?
                          pc + `XLEN'd8 :
                          (fields.sym == mips_pkg::LUI) ?
                          {fields.imm16, {(`XLEN-16){1'b0}}} : '0;

    always_comb begin
        recNext.valid        = 1'b1;
        recNext.sym          = fields.sym;
        recNext.pc           = pc;
        recNext.dataRs       = rsData;
        recNext.dataRt       = rtData;
        recNext.imm16        = fields.imm16;
        recNext.shamt        = fields.shamt;
        recNext.regWriteAddr = regWriteAddr;
        recNext.regWriteData = regWriteData;
    end

    // Output register toward execute
    assign outFree = !validQ || issueReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else if (respAccept) begin
            validQ <= 1'b1;
        end else if (issueReady) begin
            validQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (respAccept) begin
            recQ <= recNext;
        end
    end

    always_comb begin
        issue       = recQ;
        issue.valid = validQ;
    end

endmodule

// ==== source/fetchControl.sv ====
`include "mips_consts.svh"

module fetchControl (
    input  logic               clk,
    input  logic               arstN,
    input  logic               reqReady,
    input  mips_pkg::fetchResp resp,
    input  logic               outFree,
    input  logic               redirectValid,
    output logic               reqValid,
    output logic               advance,
    output logic               respReady,
    output logic               respAccept
);

    localparam int CountWidth = $clog2(`MAX_INFLIGHT + 1);

    typedef enum logic {RUN, FLUSH} ctrlState;

    ctrlState              state;
    ctrlState              stateNext;
    logic [CountWidth-1:0] inFlight;
    logic [CountWidth-1:0] inFlightNext;
    logic [CountWidth-1:0] dropCount;
    logic [CountWidth-1:0] dropNext;
    logic                  respDone;

    // Only grows through a grant, so valid never drops before its transfer
    assign reqValid = inFlight < CountWidth'(`MAX_INFLIGHT);
    assign advance  = reqValid && reqReady;

    // Responses wait for the output register in both states
    assign respReady  = outFree;
    assign respDone   = resp.valid && respReady;
    assign respAccept = resp.valid && (state == RUN) && outFree;

    assign inFlightNext = inFlight + CountWidth'(advance) - CountWidth'(respDone);

    always_comb begin
        stateNext = state;
        dropNext  = dropCount;
        if (state == RUN) begin
            // Everything still out after this cycle predates the new target,
            // including a request granted right now with the old pc
            if (redirectValid && inFlightNext != '0) begin
                stateNext = FLUSH;
                dropNext  = inFlightNext;
            end
        end else if (respDone) begin
            dropNext = dropCount - 1'b1;
            if (dropCount == CountWidth'(1)) begin
                stateNext = RUN;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= RUN;
            inFlight  <= '0;
            dropCount <= '0;
        end else begin
            state     <= stateNext;
            inFlight  <= inFlightNext;
            dropCount <= dropNext;
        end
    end

endmodule

// ==== source/fetchCounter.sv ====
`include "mips_consts.svh"

module fetchCounter (
    input  logic             clk,
    input  logic             arstN,
    input  logic             advance,
    input  logic             redirectValid,
    input  logic [`XLEN-1:0] redirectPc,
    output logic [`XLEN-1:0] pc
);

    // Redirect wins over a sequential step in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else if (redirectValid) begin
            pc <= redirectPc;
        end else if (advance) begin
            pc <= pc + `XLEN'd4;
        end
    end

endmodule

// ==== source/instrDecoder.sv ====
module instrDecoder (
    input  mips_pkg::instrWord    code,
    output mips_pkg::decodeFields fields
);

    // Special opcode, selected by funct
    function automatic mips_pkg::instrSym rSym(input logic [5:0] funct);
        case (funct)
            6'b100000: return mips_pkg::ADD;
            6'b100010: return mips_pkg::SUB;
            6'b100001: return mips_pkg::ADDU;
            6'b100011: return mips_pkg::SUBU;
            6'b100100: return mips_pkg::AND;
            6'b100101: return mips_pkg::OR;
            6'b100110: return mips_pkg::XOR;
            6'b100111: return mips_pkg::NOR;
            6'b101010: return mips_pkg::SLT;
            6'b101011: return mips_pkg::SLTU;
            6'b000000: return mips_pkg::SLL;
            6'b000100: return mips_pkg::SLLV;
            6'b000010: return mips_pkg::SRL;
            6'b000110: return mips_pkg::SRLV;
            6'b000011: return mips_pkg::SRA;
            6'b000111: return mips_pkg::SRAV;
            6'b001001: return mips_pkg::JALR;
            6'b001000: return mips_pkg::JR;
            default:   return mips_pkg::NOP;
        endcase
    endfunction

    function automatic mips_pkg::instrSym ijSym(input logic [5:0] opcode);
        case (opcode)
            6'b001000: return mips_pkg::ADDI;
            6'b001001: return mips_pkg::ADDIU;
            6'b001100: return mips_pkg::ANDI;
            6'b001101: return mips_pkg::ORI;
            6'b001110: return mips_pkg::XORI;
            6'b001111: return mips_pkg::LUI;
            6'b001010: return mips_pkg::SLTI;
            6'b001011: return mips_pkg::SLTIU;
            6'b100011: return mips_pkg::LW;
            6'b100001: return mips_pkg::LH;
            6'b100101: return mips_pkg::LHU;
            6'b100000: return mips_pkg::LB;
            6'b100100: return mips_pkg::LBU;
            6'b101011: return mips_pkg::SW;
            6'b101001: return mips_pkg::SH;
            6'b101000: return mips_pkg::SB;
            6'b000100: return mips_pkg::BEQ;
            6'b000101: return mips_pkg::BNE;
            6'b000110: return mips_pkg::BLEZ;
            6'b000111: return mips_pkg::BGTZ;
            6'b000010: return mips_pkg::J;
            6'b000011: return mips_pkg::JAL;
            default:   return mips_pkg::NOP;
        endcase
    endfunction

    always_comb begin
        fields = '0;
        if (code.rView.opcode == 6'b000000) begin
            fields.sym   = rSym(code.rView.funct);
            fields.rs    = code.rView.rs;
            fields.rt    = code.rView.rt;
            fields.rd    = code.rView.rd;
            fields.shamt = code.rView.shamt;
        end else begin
            // Regimm branches are told apart by the rt field
            if (code.ijView.opcode == 6'b000001) begin
                if (code.ijView.rt == 5'b00001) begin
                    fields.sym = mips_pkg::BGEZ;
                end else if (code.ijView.rt == 5'b00000) begin
                    fields.sym = mips_pkg::BLTZ;
                end
            end else begin
                fields.sym = ijSym(code.ijView.opcode);
            end
            fields.rs      = code.ijView.rs;
            fields.rt      = code.ijView.rt;
            fields.imm16   = code.ijView.imm16;
            fields.jmpAddr = code.jView.jmpAddr;
        end
        // All-zero word would otherwise decode as SLL
        if (code == '0) begin
            fields.sym = mips_pkg::NOP;
        end
    end

endmodule

// ==== source/mipsFrontEnd.sv ====
`include "mips_consts.svh"

module mipsFrontEnd (
    input  logic               clk,
    input  logic               arstN,
    input  logic               fetchReqReady,
    input  mips_pkg::fetchResp fetchResp,
    input  mips_pkg::wbWrite   wb,
    input  logic               issueReady,
    output mips_pkg::fetchReq  fetchReq,
    output logic               fetchRespReady,
    output mips_pkg::issueRec  issue
);

    localparam int PtrWidth   = (`MAX_INFLIGHT > 1) ? $clog2(`MAX_INFLIGHT) : 1;
    localparam int CountWidth = $clog2(`MAX_INFLIGHT + 1);

    logic [`XLEN-1:0]      pc;
    logic                  reqValid;
    logic                  advance;
    logic                  respAccept;
    logic                  outFree;
    logic                  redirectValid;
    logic [`XLEN-1:0]      redirectPc;
    mips_pkg::decodeFields fields;
    logic [`XLEN-1:0]      rsData;
    logic [`XLEN-1:0]      rtData;
    logic [`XLEN-1:0]      pcQueue [`MAX_INFLIGHT];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] qCount;
    logic                  push;
    logic                  pop;
    logic [`XLEN-1:0]      respPc;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(`MAX_INFLIGHT - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fetchReq = '{valid: reqValid, pc: pc};

    // In-order record of request addresses, one entry per request in flight
    assign push = fetchReq.valid && fetchReqReady;
    assign pop  = fetchResp.valid && fetchRespReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            qCount <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            qCount <= qCount + CountWidth'(push) - CountWidth'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pcQueue[wrPtr] <= pc;
        end
    end

    // A response in the same cycle as its request takes the live pc
    assign respPc = (qCount == '0) ? pc : pcQueue[rdPtr];

    fetchCounter fetchCounter_inst (
        .clk           (clk),
        .arstN         (arstN),
        .advance       (advance),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .pc            (pc)
    );

    fetchControl fetchControl_inst (
        .clk           (clk),
        .arstN         (arstN),
        .reqReady      (fetchReqReady),
        .resp          (fetchResp),
        .outFree       (outFree),
        .redirectValid (redirectValid),
        .reqValid      (reqValid),
        .advance       (advance),
        .respReady     (fetchRespReady),
        .respAccept    (respAccept)
    );

    instrDecoder instrDecoder_inst (
        .code   (fetchResp.code),
        .fields (fields)
    );

    regFile regFile_inst (
        .clk    (clk),
        .arstN  (arstN),
        .wEn    (wb.en),
        .wAddr  (wb.addr),
        .wData  (wb.data),
        .rAddr1 (fields.rs),
        .rAddr2 (fields.rt),
        .rData1 (rsData),
        .rData2 (rtData)
    );

    decodeStage decodeStage_inst (
        .clk           (clk),
        .arstN         (arstN),
        .pc            (respPc),
        .fields        (fields),
        .rsData        (rsData),
        .rtData        (rtData),
        .respAccept    (respAccept),
        .issueReady    (issueReady),
        .outFree       (outFree),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .issue         (issue)
    );

endmodule

// ==== source/mips_pkg.sv ====
`include "mips_consts.svh"

package mips_pkg;

    // NOP comes first so that a cleared field decodes as NOP
    typedef enum logic [5:0] {
        NOP,
        ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
        SLL, SLLV, SRL, SRLV, SRA, SRAV, JALR, JR,
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        LW, LH, LHU, LB, LBU, SW, SH, SB,
        BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, J, JAL
    } instrSym;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } ijFormat;

    // Jump target overlays rs, rt and imm16 of the I/J view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] jmpAddr;
    } jFormat;

    typedef union packed {
        rFormat  rView;
        ijFormat ijView;
        jFormat  jView;
    } instrWord;

    typedef struct packed {
        instrSym                sym;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [15:0]            imm16;
        logic [25:0]            jmpAddr;
    } decodeFields;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
    } fetchReq;

    typedef struct packed {
        logic     valid;
        instrWord code;
    } fetchResp;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } wbWrite;

    typedef struct packed {
        logic                   valid;
        instrSym                sym;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       dataRs;
        logic [`XLEN-1:0]       dataRt;
        logic [15:0]            imm16;
        logic [4:0]             shamt;
        logic [`REG_ADDR_W-1:0] regWriteAddr;
        logic [`XLEN-1:0]       regWriteData;
    } issueRec;

endpackage

// ==== source/regFile.sv ====
`include "mips_consts.svh"

module regFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   wEn,
    input  logic [`REG_ADDR_W-1:0] wAddr,
    input  logic [`XLEN-1:0]       wData,
    input  logic [`REG_ADDR_W-1:0] rAddr1,
    input  logic [`REG_ADDR_W-1:0] rAddr2,
    output logic [`XLEN-1:0]       rData1,
    output logic [`XLEN-1:0]       rData2
);

    // Register 0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // Same-cycle write shows through to the readers
    assign rData1 = (rAddr1 == '0) ? '0 :
                    (wEn && wAddr == rAddr1) ? wData : regs[rAddr1];
    assign rData2 = (rAddr2 == '0) ? '0 :
                    (wEn && wAddr == rAddr2) ? wData : regs[rAddr2];

endmodule
